/* source/rv_pkg.sv */
`default_nettype none

package rv_pkg;

   typedef logic [31:0] word_t;
   typedef logic [7:0]  byte_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [3:0]  alu_op_t;

   // upper bit selects the alternate form (sub, sra), low bits follow funct3
   localparam alu_op_t alu_add  = 4'b0000;
   localparam alu_op_t alu_sll  = 4'b0001;
   localparam alu_op_t alu_slt  = 4'b0010;
   localparam alu_op_t alu_sltu = 4'b0011;
   localparam alu_op_t alu_xor  = 4'b0100;
   localparam alu_op_t alu_srl  = 4'b0101;
   localparam alu_op_t alu_or   = 4'b0110;
   localparam alu_op_t alu_and  = 4'b0111;
   localparam alu_op_t alu_sub  = 4'b1000;
   localparam alu_op_t alu_sra  = 4'b1101;

   localparam logic [6:0] op_lui    = 7'b0110111;
   localparam logic [6:0] op_auipc  = 7'b0010111;
   localparam logic [6:0] op_jal    = 7'b1101111;
   localparam logic [6:0] op_jalr   = 7'b1100111;
   localparam logic [6:0] op_branch = 7'b1100011;
   localparam logic [6:0] op_load   = 7'b0000011;
   localparam logic [6:0] op_store  = 7'b0100011;
   localparam logic [6:0] op_imm    = 7'b0010011;
   localparam logic [6:0] op_reg    = 7'b0110011;

   // load and store access sizes
   localparam logic [2:0] f3_byte   = 3'b000;
   localparam logic [2:0] f3_half   = 3'b001;
   localparam logic [2:0] f3_word   = 3'b010;
   localparam logic [2:0] f3_byte_u = 3'b100;
   localparam logic [2:0] f3_half_u = 3'b101;

   typedef enum logic {
      fetch_state,
      execute_state
   } core_state_t;

endpackage

`default_nettype wire

/* source/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_pkg::*; (
   input  wire      clk,
   input  wire      rst,
   input  reg_idx_t rs1,
   input  reg_idx_t rs2,
   input  reg_idx_t rd,
   input  word_t    rd_data,
   input  wire      rd_write,
   output word_t    rs1_data,
   output word_t    rs2_data
);

   word_t regs [32];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (rd_write && rd != 5'd0) begin
         regs[rd] <= rd_data;
      end
   end

   // x0 never gets written, so it reads back as zero
   assign rs1_data = regs[rs1];
   assign rs2_data = regs[rs2];

endmodule

`default_nettype wire

/* source/imm_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module imm_decoder import rv_pkg::*; (
   input  word_t    inst,
   output reg_idx_t rs1,
   output reg_idx_t rs2,
   output reg_idx_t rd,
   output word_t    imm_i,
   output word_t    imm_s,
   output word_t    imm_b,
   output word_t    imm_u,
   output word_t    imm_j
);

   assign rs1 = inst[19:15];
   assign rs2 = inst[24:20];
   assign rd  = inst[11:7];

   assign imm_i = {{20{inst[31]}}, inst[31:20]};

   assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};

   // branch offset, bit 0 implied zero
   assign imm_b = {
      {19{inst[31]}},
      inst[31],
      inst[7],
      inst[30:25],
      inst[11:8],
      1'b0
   };

   assign imm_u = {inst[31:12], 12'b0};

   // jump offset, scrambled like the B form
   assign imm_j = {
      {11{inst[31]}},
      inst[31],
      inst[19:12],
      inst[20],
      inst[30:21],
      1'b0
   };

endmodule

`default_nettype wire

/* source/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import rv_pkg::*; (
   input  alu_op_t    op,
   input  word_t      a,
   input  word_t      b,
   input  wire  [2:0] funct3,
   output word_t      result,
   output logic       branch_taken
);

   logic [4:0] shamt;
   logic       lt_s;
   logic       lt_u;

   assign shamt = b[4:0];
   assign lt_s  = $signed(a) < $signed(b);
   assign lt_u  = a < b;

   always_comb begin
      case (op)
         alu_add:  result = a + b;
         alu_sub:  result = a - b;
         alu_sll:  result = a << shamt;
         alu_slt:  result = {31'b0, lt_s};
         alu_sltu: result = {31'b0, lt_u};
         alu_xor:  result = a ^ b;
         alu_srl:  result = a >> shamt;
         alu_sra:  result = word_t'($signed(a) >>> shamt);
         alu_or:   result = a | b;
         alu_and:  result = a & b;
         default:  result = '0;
      endcase
   end

   // beq bne blt bge bltu bgeu
   always_comb begin
      case (funct3)
         3'b000:  branch_taken = a == b;
         3'b001:  branch_taken = a != b;
         3'b100:  branch_taken = lt_s;
         3'b101:  branch_taken = !lt_s;
         3'b110:  branch_taken = lt_u;
         3'b111:  branch_taken = !lt_u;
         default: branch_taken = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

/* source/execute.sv */
`timescale 1ns/1ps
`default_nettype none

module execute import rv_pkg::*; (
   input  wire   clk,
   input  wire   rst,
   input  wire   exec_start,
   input  word_t inst,
   input  word_t pc,
   input  byte_t mem_rdata,
   output logic  exec_done,
   output word_t next_pc,
   output word_t data_addr,
   output byte_t data_wdata,
   output logic  data_write,
   output logic  data_active,
   output logic  invalid_inst
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   reg_idx_t   rs1, rs2, rd;
   word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
   word_t      rs1_data, rs2_data;
   word_t      rd_data;
   logic       rd_write;
   logic       is_lui, is_auipc, is_jal, is_jalr, is_branch;
   logic       is_load, is_store, is_imm, is_reg, is_valid, is_mem;
   logic       alt;
   alu_op_t    alu_op;
   word_t      alu_a, alu_b, alu_result;
   logic       branch_taken;
   word_t      pc_plus4;
   logic [1:0] cnt;
   logic [1:0] last_cnt;
   logic       last_byte;
   logic [4:0] byte_base;
   word_t      load_buf;
   word_t      load_word;
   word_t      load_ext;

   assign opcode = inst[6:0];
   assign funct3 = inst[14:12];

   assign is_lui    = opcode == op_lui;
   assign is_auipc  = opcode == op_auipc;
   assign is_jal    = opcode == op_jal;
   assign is_jalr   = opcode == op_jalr;
   assign is_branch = opcode == op_branch;
   assign is_load   = opcode == op_load;
   assign is_store  = opcode == op_store;
   assign is_imm    = opcode == op_imm;
   assign is_reg    = opcode == op_reg;
   assign is_mem    = is_load || is_store;
   assign is_valid  = is_lui || is_auipc || is_jal || is_jalr || is_branch ||
                      is_mem || is_imm || is_reg;

   imm_decoder u_imm_decoder (
      .inst  (inst),
      .rs1   (rs1),
      .rs2   (rs2),
      .rd    (rd),
      .imm_i (imm_i),
      .imm_s (imm_s),
      .imm_b (imm_b),
      .imm_u (imm_u),
      .imm_j (imm_j)
   );

   reg_file u_reg_file (
      .clk      (clk),
      .rst      (rst),
      .rs1      (rs1),
      .rs2      (rs2),
      .rd       (rd),
      .rd_data  (rd_data),
      .rd_write (rd_write),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data)
   );

   // sub and sra only; srli/srai share funct3 so inst[30] picks there too
   assign alt    = inst[30] && ((is_reg && funct3 == 3'b000) || funct3 == 3'b101);
   assign alu_op = (is_imm || is_reg) ? alu_op_t'({alt, funct3}) : alu_add;

   always_comb begin
      if (is_lui) begin
         alu_a = '0;
      end else if (is_auipc) begin
         alu_a = pc;
      end else begin
         alu_a = rs1_data;
      end
      if (is_reg || is_branch) begin
         alu_b = rs2_data;
      end else if (is_store) begin
         alu_b = imm_s;
      end else if (is_lui || is_auipc) begin
         alu_b = imm_u;
      end else begin
         alu_b = imm_i;
      end
   end

   alu u_alu (
      .op           (alu_op),
      .a            (alu_a),
      .b            (alu_b),
      .funct3       (funct3),
      .result       (alu_result),
      .branch_taken (branch_taken)
   );

   assign pc_plus4 = pc + 32'd4;

   always_comb begin
      if (is_jal) begin
         next_pc = pc + imm_j;
      end else if (is_jalr) begin
         next_pc = {alu_result[31:1], 1'b0};
      end else if (is_branch && branch_taken) begin
         next_pc = pc + imm_b;
      end else begin
         next_pc = pc_plus4;
      end
   end

   // one cycle per data byte
   assign last_cnt  = (funct3[1:0] == 2'b00) ? 2'd0 : (funct3[1:0] == 2'b01) ? 2'd1 : 2'd3;
   assign last_byte = cnt == last_cnt;
   assign byte_base = {cnt, 3'b000};

   always_ff @(posedge clk) begin
      if (rst) begin
         cnt <= '0;
      end else if (exec_start && is_mem) begin
         cnt <= last_byte ? 2'd0 : cnt + 2'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (exec_start && is_load) begin
         load_buf[byte_base +: 8] <= mem_rdata;
      end
   end

   // final byte comes straight off the bus
   always_comb begin
      load_word = load_buf;
      load_word[byte_base +: 8] = mem_rdata;
   end

   always_comb begin
      case (funct3)
         f3_byte:   load_ext = {{24{load_word[7]}}, load_word[7:0]};
         f3_half:   load_ext = {{16{load_word[15]}}, load_word[15:0]};
         f3_byte_u: load_ext = {24'b0, load_word[7:0]};
         f3_half_u: load_ext = {16'b0, load_word[15:0]};
         default:   load_ext = load_word;
      endcase
   end

   assign data_active = exec_start && is_mem;
   assign data_write  = exec_start && is_store;
   assign data_addr   = alu_result + {30'b0, cnt};
   assign data_wdata  = data_write ? rs2_data[byte_base +: 8] : '0;

   assign exec_done    = exec_start && (!is_mem || last_byte);
   assign invalid_inst = exec_start && !is_valid;

   always_comb begin
      if (is_jal || is_jalr) begin
         rd_data = pc_plus4;
      end else if (is_load) begin
         rd_data = load_ext;
      end else begin
         rd_data = alu_result;
      end
   end

   // no writeback for branches, stores or unknown opcodes
   assign rd_write = exec_done && is_valid && !is_branch && !is_store;

endmodule

`default_nettype wire

/* source/core.sv */
`timescale 1ns/1ps
`default_nettype none

module core import rv_pkg::*; #(
   parameter word_t reset_pc = 32'h0000_0000
) (
   input  wire   clk,
   input  wire   rst,
   input  byte_t mem_rdata,
   output word_t mem_addr,
   output byte_t mem_wdata,
   output logic  mem_write,
   output logic  invalid_inst
);

   core_state_t state;
   word_t       pc;
   word_t       inst;
   logic [1:0]  fetch_cnt;
   logic        exec_start;
   logic        exec_done;
   word_t       next_pc;
   word_t       data_addr;
   byte_t       data_wdata;
   logic        data_write;
   logic        data_active;
   word_t       fetch_addr;

   assign exec_start = state == execute_state;

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= fetch_state;
         pc        <= reset_pc;
         fetch_cnt <= '0;
      end else begin
         case (state)
            fetch_state: begin
               fetch_cnt <= fetch_cnt + 2'd1;
               if (fetch_cnt == 2'd3) begin
                  state <= execute_state;
               end
            end
            execute_state: begin
               if (exec_done) begin
                  pc    <= next_pc;
                  state <= fetch_state;
               end
            end
            default: state <= fetch_state;
         endcase
      end
   end

   // msb first, so each byte pushes the earlier ones up
   always_ff @(posedge clk) begin
      if (state == fetch_state) begin
         inst <= {inst[23:0], mem_rdata};
      end
   end

   assign fetch_addr = pc + {30'b0, fetch_cnt};

   execute u_execute (
      .clk          (clk),
      .rst          (rst),
      .exec_start   (exec_start),
      .inst         (inst),
      .pc           (pc),
      .mem_rdata    (mem_rdata),
      .exec_done    (exec_done),
      .next_pc      (next_pc),
      .data_addr    (data_addr),
      .data_wdata   (data_wdata),
      .data_write   (data_write),
      .data_active  (data_active),
      .invalid_inst (invalid_inst)
   );

   // data access owns the bus while a load or store runs
   assign mem_addr  = data_active ? data_addr : fetch_addr;
   assign mem_wdata = data_wdata;
   assign mem_write = data_active && data_write;

endmodule

`default_nettype wire

/* bench/rv_tb_pkg.sv */
`default_nettype none

package rv_tb_pkg;

   import rv_pkg::*;

   localparam int mem_size = 4096;

   // {check addr, invalid, write, wdata, addr}
   typedef logic [42:0] bus_event_t;

   function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                    input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
      return {f7, rs2, rs1, f3, rd, op_reg};
   endfunction

   function automatic word_t i_type(input logic [6:0] opc, input logic [2:0] f3,
                                    input reg_idx_t rd, input reg_idx_t rs1, input logic [11:0] imm);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic word_t s_type(input logic [2:0] f3, input reg_idx_t rs1,
                                    input reg_idx_t rs2, input logic [11:0] imm);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
   endfunction

   function automatic word_t b_type(input logic [2:0] f3, input reg_idx_t rs1,
                                    input reg_idx_t rs2, input logic [12:0] imm);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
   endfunction

   function automatic word_t u_type(input logic [6:0] opc, input reg_idx_t rd,
                                    input logic [19:0] imm);
      return {imm, rd, opc};
   endfunction

   function automatic word_t j_type(input reg_idx_t rd, input logic [20:0] imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
   endfunction

   function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                     input word_t a, input word_t b);
      case (f3)
         3'd0:    return alt ? a - b : a + b;
         3'd1:    return a << b[4:0];
         3'd2:    return {31'b0, $signed(a) < $signed(b)};
         3'd3:    return {31'b0, a < b};
         3'd4:    return a ^ b;
         3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'd6:    return a | b;
         default: return a & b;
      endcase
   endfunction

   // expected bus activity, one entry per clock after reset
   function automatic void rv_model(input byte_t mem [mem_size], input word_t start_pc,
                                    input int n_inst, ref bus_event_t events[$]);
      word_t      x [32];
      word_t      pc;
      word_t      ins;
      word_t      nxt;
      word_t      val;
      word_t      ea;
      word_t      a;
      word_t      b;
      logic       wr;
      logic       inv;
      logic       tk;
      int         nbytes;
      for (int i = 0; i < 32; i++) begin
         x[i] = '0;
      end
      pc = start_pc;
      for (int n = 0; n < n_inst; n++) begin
         for (int k = 0; k < 4; k++) begin
            ins = {ins[23:0], mem[12'(pc + word_t'(k))]};
            events.push_back({1'b1, 1'b0, 1'b0, 8'h00, pc + word_t'(k)});
         end
         a      = x[ins[19:15]];
         b      = x[ins[24:20]];
         nxt    = pc + 4;
         val    = '0;
         wr     = 1'b1;
         inv    = 1'b0;
         nbytes = (ins[13:12] == 2'd0) ? 1 : (ins[13:12] == 2'd1) ? 2 : 4;
         case (ins[6:0])
            op_lui:   val = {ins[31:12], 12'b0};
            op_auipc: val = pc + {ins[31:12], 12'b0};
            op_jal: begin
               val = pc + 4;
               nxt = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            op_jalr: begin
               val = pc + 4;
               nxt = (a + {{20{ins[31]}}, ins[31:20]}) & ~32'd1;
            end
            op_branch: begin
               wr = 1'b0;
               // funct3 bit 0 inverts eq, lt and ltu
               tk = ins[14] ? (ins[13] ? a < b : $signed(a) < $signed(b)) : a == b;
               if (tk ^ ins[12]) begin
                  nxt = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
               end
            end
            op_load: begin
               ea = a + {{20{ins[31]}}, ins[31:20]};
               for (int k = 0; k < nbytes; k++) begin
                  val[8*k +: 8] = mem[12'(ea + word_t'(k))];
                  events.push_back({1'b1, 1'b0, 1'b0, 8'h00, ea + word_t'(k)});
               end
               if (ins[14:12] == f3_byte) begin
                  val = {{24{val[7]}}, val[7:0]};
               end else if (ins[14:12] == f3_half) begin
                  val = {{16{val[15]}}, val[15:0]};
               end
            end
            op_store: begin
               wr = 1'b0;
               ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
               for (int k = 0; k < nbytes; k++) begin
                  mem[12'(ea + word_t'(k))] = b[8*k +: 8];
                  events.push_back({1'b1, 1'b0, 1'b1, b[8*k +: 8], ea + word_t'(k)});
               end
            end
            op_imm:  val = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'd5, a,
                                   {{20{ins[31]}}, ins[31:20]});
            op_reg:  val = alu_ref(ins[14:12], ins[30], a, b);
            default: begin
               wr  = 1'b0;
               inv = 1'b1;
            end
         endcase
         // single execute cycle, bus address not defined there
         if (ins[6:0] != op_load && ins[6:0] != op_store) begin
            events.push_back({1'b0, inv, 1'b0, 8'h00, pc});
         end
         if (wr && ins[11:7] != 5'd0) begin
            x[ins[11:7]] = val;
         end
         pc = nxt;
      end
   endfunction

endpackage

`default_nettype wire

/* bench/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_tb import rv_pkg::*, rv_tb_pkg::*; ();

   logic       clk;
   logic       rst;
   byte_t      mem_rdata;
   word_t      mem_addr;
   byte_t      mem_wdata;
   logic       mem_write;
   logic       invalid_inst;
   byte_t      mem [mem_size];
   word_t      prog [$];
   bus_event_t expected [$];
   int         cycles = 0;
   int         limit = 100;

   core #(.reset_pc(32'h0000_0000)) UUT (
      .clk          (clk),
      .rst          (rst),
      .mem_rdata    (mem_rdata),
      .mem_addr     (mem_addr),
      .mem_wdata    (mem_wdata),
      .mem_write    (mem_write),
      .invalid_inst (invalid_inst)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #50 clk = ~clk;
      end
   end

   assign mem_rdata = mem[mem_addr[11:0]];

   always @(posedge clk) begin
      if (mem_write) begin
         mem[mem_addr[11:0]] <= mem_wdata;
      end
   end

   task automatic emit(input word_t w);
      prog.push_back(w);
   endtask

   task automatic compare(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("ERR %s got %h expected %h", name, got, exp);
         $display("Errors found");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   initial begin
      reg_idx_t    rd;
      logic [2:0]  f3;
      logic [11:0] imm;
      logic [6:0]  f7;
      rst = 1'b1;
      void'($urandom(32'hccb6));
      for (int a = 0; a < mem_size; a++) begin
         mem[a] = byte_t'((a * 37) ^ (a >> 5));
      end
      // x1 points at the data area
      emit(i_type(op_imm, 3'd0, 5'd1, 5'd0, 12'd1024));
      emit(u_type(op_lui, 5'd2, 20'h12345));
      emit(i_type(op_imm, 3'd0, 5'd2, 5'd2, 12'h678));
      emit(s_type(f3_word, 5'd1, 5'd2, 12'd0));
      emit(s_type(f3_half, 5'd1, 5'd2, 12'd4));
      emit(s_type(f3_byte, 5'd1, 5'd2, 12'd6));
      emit(i_type(op_imm, 3'd0, 5'd3, 5'd0, 12'hf80));
      emit(s_type(f3_word, 5'd1, 5'd3, 12'd8));
      emit(i_type(op_load, f3_byte, 5'd4, 5'd1, 12'd8));
      emit(i_type(op_load, f3_byte_u, 5'd5, 5'd1, 12'd8));
      emit(i_type(op_load, f3_half, 5'd6, 5'd1, 12'd8));
      emit(i_type(op_load, f3_half_u, 5'd7, 5'd1, 12'd9));
      emit(i_type(op_load, f3_word, 5'd8, 5'd1, 12'd0));
      for (int r = 4; r <= 8; r++) begin
         emit(s_type(f3_word, 5'd1, reg_idx_t'(r), 12'(4 * r - 4)));
      end
      // taken beq, untaken bne, jal and jalr each skip one addi
      emit(b_type(3'b000, 5'd0, 5'd0, 13'd8));
      emit(i_type(op_imm, 3'd0, 5'd9, 5'd0, 12'd1));
      emit(b_type(3'b001, 5'd0, 5'd0, 13'd8));
      emit(j_type(5'd10, 21'd8));
      emit(i_type(op_imm, 3'd0, 5'd9, 5'd0, 12'd2));
      emit(s_type(f3_word, 5'd1, 5'd10, 12'd32));
      emit(u_type(op_auipc, 5'd12, 20'd0));
      emit(i_type(op_jalr, 3'd0, 5'd11, 5'd12, 12'd12));
      emit(i_type(op_imm, 3'd0, 5'd9, 5'd0, 12'd3));
      emit(s_type(f3_word, 5'd1, 5'd11, 12'd36));
      emit(s_type(f3_word, 5'd1, 5'd12, 12'd40));
      emit(32'h0000_0073);
      // unsupported csrrw with rd x9
      emit(i_type(7'b1110011, 3'd1, 5'd9, 5'd1, 12'h300));
      emit(s_type(f3_word, 5'd1, 5'd9, 12'd44));
      // random alu ops with every result stored
      for (int i = 0; i < 40; i++) begin
         rd  = reg_idx_t'(2 + $urandom % 30);
         f3  = 3'($urandom);
         imm = 12'($urandom);
         f7  = ((f3 == 3'd0 || f3 == 3'd5) && $urandom % 2) ? 7'h20 : 7'h00;
         if ($urandom % 2) begin
            emit(r_type(f7, f3, rd, 5'($urandom), 5'($urandom)));
         end else begin
            if (f3 == 3'd1 || f3 == 3'd5) begin
               imm[11:5] = f3[2] ? f7 : 7'h00;
            end
            emit(i_type(op_imm, f3, rd, 5'($urandom), imm));
         end
         emit(s_type(f3_word, 5'd1, rd, 12'(48 + 4 * i)));
      end
      emit(j_type(5'd0, 21'd0));
      for (int i = 0; i < prog.size(); i++) begin
         {mem[4*i], mem[4*i+1], mem[4*i+2], mem[4*i+3]} = prog[i];
      end
      rv_model(mem, 32'h0000_0000, prog.size() + 8, expected);
      limit = (prog.size() + 8) * 8 + 100;
      repeat (10) @(posedge clk);
      rst <= 1'b0;
   end

   always @(posedge clk) begin
      bus_event_t ev;
      if (!rst) begin
         cycles++;
         if (cycles > limit) begin
            $display("timeout after %0d cycles with events still pending", cycles);
            $display("Errors found");
            $fatal(1, "timeout");
         end else begin
            ev = expected.pop_front();
            if (ev[42]) begin
               compare("mem_addr", mem_addr, ev[31:0]);
            end
            compare("mem_write", word_t'(mem_write), word_t'(ev[40]));
            if (ev[40]) begin
               compare("mem_wdata", word_t'(mem_wdata), word_t'(ev[39:32]));
            end
            compare("invalid_inst", word_t'(invalid_inst), word_t'(ev[41]));
            if (expected.size() == 0) begin
               $display("No errors");
               $finish;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* tb.f */
source/rv_pkg.sv
source/reg_file.sv
source/imm_decoder.sv
source/alu.sv
source/execute.sv
source/core.sv
bench/rv_tb_pkg.sv
bench/core_tb.sv

/* Bender.yml */
package:
  name: rv_byte_core

sources:
  - source/rv_pkg.sv
  - source/reg_file.sv
  - source/imm_decoder.sv
  - source/alu.sv
  - source/execute.sv
  - source/core.sv
  - target: test
    files:
      - bench/rv_tb_pkg.sv
      - bench/core_tb.sv
